//--- all.f
common/fetch_pkg.sv
common/refill_if.sv
ifu/ifu.sv
icache/icache.sv
rtl/axi_refill.sv
rtl/fetch_top.sv
testbench/fetch_tb.sv

//--- common/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // word address, the two low zero bits are dropped
    typedef logic [29:0] pc_t;

    // {pc, inst} as seen by decode
    typedef logic [61:0] fetch_pkt_t;

    localparam int BLOCK_WORDS = 4;

    typedef logic [BLOCK_WORDS*32-1:0] block_t;

    // byte offset bits inside one block
    localparam int BLOCK_OFFSET_BITS = $clog2(BLOCK_WORDS * 4);

    // word address of 0x8000_0000
    localparam pc_t PC_RESET = 30'h2000_0000;

    // SDRAM lives at 0xA000_0000 to 0xBFFF_FFFF
    localparam logic [3:0] SDRAM_BASE_NIB = 4'hA;
    localparam logic [3:0] SDRAM_END_NIB = 4'hB;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_WORD = 3'd2;

endpackage

//--- common/refill_if.sv
`timescale 1ns/10ps

interface refill_if import fetch_pkg::*; ();

    // level from the cache, held until ready
    logic req;
    // block-aligned byte address
    addr_t addr;
    block_t data;
    // single-cycle pulse once the block is assembled
    logic ready;
    // qualified by ready
    logic fault;

    modport cache (
        output req,
        output addr,
        input  data,
        input  ready,
        input  fault
    );

    modport mem (
        input  req,
        input  addr,
        output data,
        output ready,
        output fault
    );

endinterface

//--- icache/icache.sv
`timescale 1ns/10ps

module icache import fetch_pkg::*; #(
    parameter int LINES = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t fetch_addr,
    output logic  hit,
    output word_t inst,
    refill_if.cache refill
);

    localparam int INDEX_BITS = $clog2(LINES);
    localparam int WORD_BITS = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS = 32 - BLOCK_OFFSET_BITS - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    logic [LINES-1:0] valid_q;
    tag_t tag_q [LINES];
    block_t data_q [LINES];

    index_t lookup_index;
    tag_t lookup_tag;
    logic [WORD_BITS-1:0] lookup_word;
    index_t fill_index;
    tag_t fill_tag;

    logic req_q;
    addr_t req_addr_q;

    assign lookup_index = fetch_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign lookup_tag = fetch_addr[31 -: TAG_BITS];
    assign lookup_word = fetch_addr[2 +: WORD_BITS];

    // the fill goes to the line of the pending request
    assign fill_index = req_addr_q[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign fill_tag = req_addr_q[31 -: TAG_BITS];

    assign hit = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign inst = data_q[lookup_index][lookup_word*$bits(word_t) +: $bits(word_t)];

    assign refill.req = req_q;
    assign refill.addr = req_addr_q;

    // one request at a time, released the cycle after ready
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
        end else if (req_q) begin
            if (refill.ready) begin
                req_q <= 1'b0;
            end
        end else if (!hit) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!req_q && !hit) begin
            req_addr_q <= {fetch_addr[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (refill.ready) begin
            // faulting blocks are installed too
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill.ready) begin
            tag_q[fill_index] <= fill_tag;
            data_q[fill_index] <= refill.data;
        end
    end

    // a completed fill serves the fetch that missed
    fill_hit_a: assert property (
        @(posedge clk) disable iff (rst)
        refill.ready |=> hit
    );

endmodule

//--- ifu/ifu.sv
`timescale 1ns/10ps

module ifu import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       idu_ready,
    input  logic       exu_dnpc_valid,
    input  pc_t        exu_dnpc,
    output logic       ifu_valid,
    output fetch_pkt_t fetch_pkt,
    output addr_t      fetch_addr,
    input  logic       hit,
    input  word_t      inst
);

    typedef enum logic {
        fetch_idle,
        fetch_wait
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_next;
    pc_t pc;
    pc_t pc_next;
    logic pc_update;

    assign fetch_addr = {pc, 2'b00};

    // wait state covers the whole refill of a missed block
    always_comb begin
        state_next = state;
        case (state)
            fetch_idle: begin
                if (idu_ready && !hit) begin
                    state_next = fetch_wait;
                end
            end
            fetch_wait: begin
                if (idu_ready && hit) begin
                    state_next = fetch_idle;
                end
            end
            default: begin
                state_next = fetch_idle;
            end
        endcase
    end

    // an update always comes with a hit on the current pc
    assign pc_update = (state_next == fetch_idle) && idu_ready;
    assign pc_next = exu_dnpc_valid ? exu_dnpc : pc + pc_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fetch_idle;
            pc <= PC_RESET;
        end else begin
            state <= state_next;
            if (pc_update) begin
                pc <= pc_next;
            end
        end
    end

    // valid is held while decode stalls so the packet is not lost
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifu_valid <= 1'b0;
        end else if (pc_update) begin
            // wrong-path packet is dropped when the execute stage redirects
            ifu_valid <= !exu_dnpc_valid;
        end else if (idu_ready) begin
            ifu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_update) begin
            fetch_pkt <= {pc, inst};
        end
    end

endmodule

//--- rtl/axi_refill.sv
`timescale 1ns/10ps

module axi_refill import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    refill_if.mem       refill,
    output logic        access_fault,
    output logic        arvalid,
    input  logic        arready,
    output addr_t       araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  word_t       rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    localparam int CNT_BITS = $clog2(BLOCK_WORDS);

    typedef enum logic [1:0] {
        refill_idle,
        refill_addr,
        refill_data
    } refill_state_t;

    refill_state_t state;
    logic is_sdram;
    logic [CNT_BITS-1:0] beat_cnt;
    logic fault_seen;
    logic ready_q;
    logic beat;
    logic last_beat;
    block_t block_q;

    assign arid = '0;
    assign arsize = AXI_SIZE_WORD;
    assign arlen = is_sdram ? 8'(BLOCK_WORDS - 1) : 8'd0;
    assign arburst = is_sdram ? AXI_BURST_INCR : AXI_BURST_FIXED;

    assign beat = (state == refill_data) && rvalid && rready;
    // single-beat mode ends on the count, bursts on rlast
    assign last_beat = is_sdram ? rlast : (beat_cnt == CNT_BITS'(BLOCK_WORDS - 1));

    assign refill.data = block_q;
    assign refill.ready = ready_q;
    assign refill.fault = access_fault;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= refill_idle;
            is_sdram <= 1'b0;
            beat_cnt <= '0;
            fault_seen <= 1'b0;
            ready_q <= 1'b0;
            access_fault <= 1'b0;
            arvalid <= 1'b0;
            araddr <= '0;
            rready <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state)
                refill_idle: begin
                    // req is still high during the ready pulse
                    if (refill.req && !ready_q) begin
                        is_sdram <= (refill.addr[31:28] == SDRAM_BASE_NIB) ||
                                    (refill.addr[31:28] == SDRAM_END_NIB);
                        araddr <= refill.addr;
                        arvalid <= 1'b1;
                        beat_cnt <= '0;
                        fault_seen <= 1'b0;
                        access_fault <= 1'b0;
                        state <= refill_addr;
                    end
                end
                refill_addr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                        state <= refill_data;
                    end
                end
                refill_data: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        fault_seen <= fault_seen || (rresp != AXI_RESP_OKAY);
                        rready <= 1'b0;
                        if (last_beat) begin
                            ready_q <= 1'b1;
                            access_fault <= fault_seen || (rresp != AXI_RESP_OKAY);
                            state <= refill_idle;
                        end else if (is_sdram) begin
                            rready <= 1'b1;
                        end else begin
                            // next word as its own AR
                            araddr <= araddr + 32'd4;
                            arvalid <= 1'b1;
                            state <= refill_addr;
                        end
                    end
                end
                default: begin
                    state <= refill_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            block_q[beat_cnt*$bits(word_t) +: $bits(word_t)] <= rdata;
        end
    end

    burst_rlast_a: assert property (
        @(posedge clk) disable iff (rst)
        (beat && is_sdram) |-> (rlast == (beat_cnt == CNT_BITS'(BLOCK_WORDS - 1)))
    );

    read_id_a: assert property (
        @(posedge clk) disable iff (rst)
        beat |-> (rid == '0)
    );

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; #(
    parameter int LINES = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        idu_ready,
    input  logic        exu_dnpc_valid,
    input  pc_t         exu_dnpc,
    output logic        ifu_valid,
    output fetch_pkt_t  fetch_pkt,
    output logic        access_fault,
    output logic        arvalid,
    input  logic        arready,
    output addr_t       araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  word_t       rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    addr_t fetch_addr;
    logic hit;
    word_t inst;

    refill_if refill_bus ();

    ifu ifu0 (
        .clk            (clk),
        .rst            (rst),
        .idu_ready      (idu_ready),
        .exu_dnpc_valid (exu_dnpc_valid),
        .exu_dnpc       (exu_dnpc),
        .ifu_valid      (ifu_valid),
        .fetch_pkt      (fetch_pkt),
        .fetch_addr     (fetch_addr),
        .hit            (hit),
        .inst           (inst)
    );

    icache #(
        .LINES (LINES)
    ) icache0 (
        .clk        (clk),
        .rst        (rst),
        .fetch_addr (fetch_addr),
        .hit        (hit),
        .inst       (inst),
        .refill     (refill_bus.cache)
    );

    axi_refill axi_refill0 (
        .clk          (clk),
        .rst          (rst),
        .refill       (refill_bus.mem),
        .access_fault (access_fault),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .arid         (arid),
        .arlen        (arlen),
        .arsize       (arsize),
        .arburst      (arburst),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rlast        (rlast),
        .rid          (rid)
    );

endmodule

//--- run.sh
#!/bin/bash
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fetch_tb -f all.f -o fetch_sim \
    && (./obj_dir/fetch_sim > sim.log 2>&1; cat sim.log) \
    && grep -q "All tests passed!" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- testbench/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam int MAX_STEPS = 18;
    localparam int CLK_PERIOD = 100;
    localparam int STALL_CYCLES = 5;

    logic clk;
    logic rst;
    logic idu_ready;
    logic exu_dnpc_valid;
    pc_t exu_dnpc;
    logic ifu_valid;
    fetch_pkt_t fetch_pkt;
    logic access_fault;
    logic arvalid;
    logic arready;
    addr_t araddr;
    logic [3:0] arid;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic rvalid;
    logic rready;
    word_t rdata;
    logic [1:0] rresp;
    logic rlast;
    logic [3:0] rid;

    // stimulus table
    logic step_stall [MAX_STEPS];
    logic step_redir [MAX_STEPS];
    addr_t step_target [MAX_STEPS];
    addr_t step_exp [MAX_STEPS];
    logic step_hit [MAX_STEPS];
    // 0 or 1 checks access_fault after the delivery, 2 skips it
    logic [1:0] step_fault [MAX_STEPS];
    int n_steps;

    logic [31:0] rng_state;
    pc_t ref_pc;
    int deliv_cnt;
    addr_t last_addr;
    int ar_cnt;
    int single_idx;
    addr_t last_single;
    addr_t last_burst;
    logic redir_taken;

    fetch_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .idu_ready      (idu_ready),
        .exu_dnpc_valid (exu_dnpc_valid),
        .exu_dnpc       (exu_dnpc),
        .ifu_valid      (ifu_valid),
        .fetch_pkt      (fetch_pkt),
        .access_fault   (access_fault),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .arid           (arid),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rlast          (rlast),
        .rid            (rid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic word_t mem_word(addr_t a);
        return a ^ 32'h5A5A_5A5A;
    endfunction

    function automatic logic is_sdram_addr(addr_t a);
        return (a[31:28] == 4'hA) || (a[31:28] == 4'hB);
    endfunction

    task automatic report_mismatch(string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic add_step(logic stall, logic redir, addr_t target, addr_t exp,
                            logic hit, logic [1:0] fault);
        step_stall[n_steps] = stall;
        step_redir[n_steps] = redir;
        step_target[n_steps] = target;
        step_exp[n_steps] = exp;
        step_hit[n_steps] = hit;
        step_fault[n_steps] = fault;
        n_steps++;
    endtask

    // AXI slave, one request at a time
    initial begin
        int delay;
        int len;
        addr_t base;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        rlast = 1'b0;
        rid = '0;
        rng_state = 32'd20;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                delay = int'(xorshift() % 32'd4);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                arready = 1'b1;
                base = araddr;
                len = int'(arlen);
                @(posedge clk);
                #1;
                arready = 1'b0;
                for (int b = 0; b <= len; b++) begin
                    rvalid = 1'b1;
                    rdata = mem_word(base + 32'(4 * b));
                    // SLVERR window
                    rresp = (base >= 32'h8000_1000 && base <= 32'h8000_10FF) ? 2'b10 : 2'b00;
                    rlast = (b == len);
                    @(negedge clk);
                    while (!rready) @(negedge clk);
                    @(posedge clk);
                    #1;
                    rvalid = 1'b0;
                    rlast = 1'b0;
                end
            end
        end
    end

    // decode side monitor, values sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && ifu_valid && idu_ready) begin
            assert (fetch_pkt[61:32] == ref_pc) else
                report_mismatch($sformatf("pc %h, expected %h",
                                          {fetch_pkt[61:32], 2'b00}, {ref_pc, 2'b00}));
            assert (fetch_pkt[31:0] == mem_word({ref_pc, 2'b00})) else
                report_mismatch($sformatf("inst %h at pc %h", fetch_pkt[31:0],
                                          {ref_pc, 2'b00}));
            last_addr = {fetch_pkt[61:32], 2'b00};
            ref_pc = ref_pc + pc_t'(1);
            deliv_cnt++;
        end
        if (!rst && exu_dnpc_valid && dut0.ifu0.pc_update) begin
            ref_pc = exu_dnpc;
            redir_taken = 1'b1;
        end
    end

    // AR channel monitor
    always @(negedge clk) begin
        if (!rst && arvalid && arready) begin
            ar_cnt++;
            assert (arsize == 3'd2 && arid == 4'd0) else
                report_mismatch($sformatf("arsize %0d arid %0d", arsize, arid));
            if (is_sdram_addr(araddr)) begin
                assert (arlen == 8'd3 && arburst == 2'b01 && araddr[3:0] == 4'h0
                        && single_idx == 0) else
                    report_mismatch($sformatf("burst AR %h len %0d burst %0d",
                                              araddr, arlen, arburst));
                assert (araddr != last_burst) else
                    report_mismatch($sformatf("second burst AR for block %h", araddr));
                last_burst = araddr;
            end else begin
                assert (arlen == 8'd0 && arburst == 2'b00
                        && araddr[3:2] == 2'(single_idx)) else
                    report_mismatch($sformatf("single AR %h len %0d burst %0d",
                                              araddr, arlen, arburst));
                if (single_idx != 0) begin
                    assert (araddr == last_single + 32'd4) else
                        report_mismatch($sformatf("single AR %h after %h",
                                                  araddr, last_single));
                end
                last_single = araddr;
                single_idx = (single_idx + 1) % BLOCK_WORDS;
            end
        end
    end

    initial begin
        #((MAX_STEPS * 200 + 10) * CLK_PERIOD);
        $display("Timeout: the fetch unit stopped delivering packets");
        $display("Test failures found");
        $fatal(1);
    end

    initial begin
        int start_cnt;
        int start_ar;
        fetch_pkt_t held_pkt;
        logic held_valid;
        clk = 1'b0;
        rst = 1'b1;
        idu_ready = 1'b0;
        exu_dnpc_valid = 1'b0;
        exu_dnpc = '0;
        ref_pc = PC_RESET;
        deliv_cnt = 0;
        ar_cnt = 0;
        single_idx = 0;
        last_single = '0;
        last_burst = '0;
        last_addr = '0;
        redir_taken = 1'b0;
        n_steps = 0;

        add_step(0, 0, '0, 32'h8000_0000, 0, 2'd0);
        add_step(0, 0, '0, 32'h8000_0004, 0, 2'd2);
        add_step(0, 0, '0, 32'h8000_0008, 0, 2'd2);
        add_step(0, 0, '0, 32'h8000_000C, 0, 2'd2);
        add_step(0, 0, '0, 32'h8000_0010, 0, 2'd0);
        add_step(1, 0, '0, 32'h8000_0014, 0, 2'd2);
        add_step(0, 0, '0, 32'h8000_0018, 0, 2'd2);
        add_step(0, 1, 32'hA000_0040, 32'hA000_0040, 0, 2'd0);
        add_step(0, 0, '0, 32'hA000_0044, 0, 2'd2);
        add_step(1, 0, '0, 32'hA000_0048, 0, 2'd2);
        add_step(0, 0, '0, 32'hA000_004C, 0, 2'd2);
        add_step(0, 0, '0, 32'hA000_0050, 0, 2'd2);
        add_step(0, 1, 32'h8000_0004, 32'h8000_0004, 1, 2'd2);
        add_step(0, 0, '0, 32'h8000_0008, 1, 2'd2);
        add_step(0, 1, 32'h8000_1000, 32'h8000_1000, 0, 2'd1);
        add_step(0, 0, '0, 32'h8000_1004, 0, 2'd2);
        add_step(0, 1, 32'h8000_0030, 32'h8000_0030, 0, 2'd0);
        add_step(0, 0, '0, 32'h8000_0034, 0, 2'd2);

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idu_ready = 1'b1;

        for (int i = 0; i < n_steps; i++) begin
            start_cnt = deliv_cnt;
            if (step_stall[i]) begin
                idu_ready = 1'b0;
                repeat (STALL_CYCLES) begin
                    held_pkt = fetch_pkt;
                    held_valid = ifu_valid;
                    @(posedge clk);
                    #1;
                    assert (held_valid || !ifu_valid) else
                        report_mismatch("packet committed while decode stalled");
                    if (ifu_valid) begin
                        assert (fetch_pkt == held_pkt) else
                            report_mismatch("fetch_pkt changed while decode stalled");
                    end
                end
                idu_ready = 1'b1;
            end
            if (step_redir[i]) begin
                redir_taken = 1'b0;
                exu_dnpc_valid = 1'b1;
                exu_dnpc = step_target[i][31:2];
                while (!redir_taken) @(posedge clk);
                #1;
                exu_dnpc_valid = 1'b0;
                start_cnt = deliv_cnt;
            end
            start_ar = ar_cnt;
            while (deliv_cnt == start_cnt) @(posedge clk);
            #1;
            assert (last_addr == step_exp[i]) else
                report_mismatch($sformatf("step %0d delivered %h, expected %h",
                                          i, last_addr, step_exp[i]));
            if (step_hit[i]) begin
                assert (ar_cnt == start_ar) else
                    report_mismatch($sformatf("step %0d hit issued an AR", i));
            end
            if (step_fault[i] != 2'd2) begin
                assert (access_fault == step_fault[i][0]) else
                    report_mismatch($sformatf("step %0d access_fault %0b", i, access_fault));
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule
